// ==== design/byte_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       i_wr,
   input  wire logic [7:0] i_din,
   input  wire logic       i_rd,
   output logic [7:0]      o_dout,
   output logic            o_full,
   output logic            o_empty
);

   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   logic [7:0]      mem [FIFO_DEPTH];
   logic [ADDR_W:0] wr_ptr; // Extra MSB marks the wrap
   logic [ADDR_W:0] rd_ptr;
   logic            do_wr;
   logic            do_rd;

   assign do_wr = i_wr && !o_full;
   assign do_rd = i_rd && !o_empty;

   assign o_empty = (wr_ptr == rd_ptr);
   assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // Head entry is always visible
   assign o_dout = mem[rd_ptr[ADDR_W-1:0]];

   always_ff @(posedge clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr[ADDR_W-1:0]] <= i_din;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/hex_line_formatter.sv ====
`timescale 1ns/100ps
`default_nettype none

module hex_line_formatter #(
   parameter int DATA_W = 16
) (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              i_stb,
   input  wire logic [DATA_W-1:0] i_data,
   input  wire logic [1:0]        i_reg_num,
   input  wire logic              i_full,
   output logic                   o_wr,
   output logic [7:0]             o_byte,
   output logic                   o_busy
);

   import uart_dbg_pkg::*;

   localparam int NIBBLES = DATA_W / 4;
   localparam int ST_W    = $clog2(NIBBLES + 6);

   // Hex digit states sit between S_HEX0 and S_LF without names of their own
   typedef enum logic [ST_W-1:0] {
      S_IDLE  = ST_W'(0),
      S_R     = ST_W'(1),
      S_DIGIT = ST_W'(2),
      S_COLON = ST_W'(3),
      S_HEX0  = ST_W'(4),
      S_LF    = ST_W'(NIBBLES + 4),
      S_CR    = ST_W'(NIBBLES + 5)
   } state_t;

   state_t            state;
   logic [DATA_W-1:0] value_q; // Top nibble is the next digit out
   logic [1:0]        reg_q;
   logic              wr_done;

   assign o_busy  = (state != S_IDLE);
   assign o_wr    = o_busy;
   assign wr_done = o_wr && !i_full;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= S_IDLE;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (i_stb)
               begin
                  state <= S_R;
               end
            end
            S_CR:
            begin
               if (wr_done)
               begin
                  state <= S_IDLE;
               end
            end
            default:
            begin
               if (wr_done)
               begin
                  state <= state_t'(state + 1'b1);
               end
            end
         endcase
      end
   end

   // Captured line payload
   always_ff @(posedge clk)
   begin
      if (state == S_IDLE && i_stb)
      begin
         value_q <= i_data;
         reg_q   <= i_reg_num;
      end
      else if (wr_done && state >= S_HEX0 && state < S_LF)
      begin
         value_q <= {value_q[DATA_W-5:0], 4'h0}; // Next nibble up
      end
   end

   always_comb
   begin
      case (state)
         S_R:     o_byte = ASCII_R;
         S_DIGIT: o_byte = ASCII_ZERO + {6'd0, reg_q};
         S_COLON: o_byte = ASCII_COLON;
         S_LF:    o_byte = ASCII_LF;
         S_CR:    o_byte = ASCII_CR;
         default: o_byte = nib_to_ascii(value_q[DATA_W-1 -: 4]);
      endcase
   end

endmodule

`default_nettype wire

// ==== design/uart_dbg_pkg.sv ====
`default_nettype none

package uart_dbg_pkg;

   // Fixed characters of a console line
   localparam logic [7:0] ASCII_R     = 8'h52;
   localparam logic [7:0] ASCII_COLON = 8'h3a;
   localparam logic [7:0] ASCII_LF    = 8'h0a;
   localparam logic [7:0] ASCII_CR    = 8'h0d;

   // Bases for digit conversion
   localparam logic [7:0] ASCII_ZERO    = 8'h30;
   localparam logic [7:0] ASCII_UPPER_A = 8'h41;

   // One received character and its stop-bit status
   typedef struct packed {
      logic [7:0] data;
      logic       frame_err; // Stop bit sampled low
   } rx_result_t;

   // Upper-case hex digit for one nibble
   function automatic logic [7:0] nib_to_ascii(input logic [3:0] nib);
      logic [7:0] ext;
      ext = {4'h0, nib};
      if (nib < 4'd10)
      begin
         return ASCII_ZERO + ext;
      end
      else
      begin
         return ASCII_UPPER_A + ext - 8'd10;
      end
   endfunction

endpackage

`default_nettype wire

// ==== design/uart_dbg_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_dbg_top #(
   parameter int DATA_W       = 16,
   parameter int CLKS_PER_BIT = 16,
   parameter int FIFO_DEPTH   = 4
) (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              i_tx_stb,
   input  wire logic [DATA_W-1:0] i_tx_data,
   input  wire logic [1:0]        i_reg_num,
   input  wire logic              i_rx,
   output logic                   o_tx_busy,
   output logic                   o_tx,
   output uart_dbg_pkg::rx_result_t o_rx,
   output logic                   o_rx_valid
);

   logic       fmt_wr;
   logic [7:0] fmt_byte;
   logic       fifo_full;
   logic       fifo_empty;
   logic [7:0] fifo_dout;
   logic       tx_active;
   logic       launch;
   logic       launch_q;  // One-cycle start pulse
   logic [7:0] tx_byte_q;

   hex_line_formatter #(.DATA_W(DATA_W)) u_fmt (
      .clk(clk), .rst(rst),
      .i_stb(i_tx_stb), .i_data(i_tx_data), .i_reg_num(i_reg_num),
      .i_full(fifo_full), .o_wr(fmt_wr), .o_byte(fmt_byte), .o_busy(o_tx_busy)
   );

   byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst(rst),
      .i_wr(fmt_wr), .i_din(fmt_byte), .i_rd(launch),
      .o_dout(fifo_dout), .o_full(fifo_full), .o_empty(fifo_empty)
   );

   // Skip a cycle after each launch so busy has time to rise
   assign launch = !fifo_empty && !tx_active && !launch_q;

   always_ff @(posedge clk)
   begin
      if (rst)
         launch_q <= 1'b0;
      else
         launch_q <= launch;
   end

   always_ff @(posedge clk)
   begin
      if (launch)
         tx_byte_q <= fifo_dout;
   end

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
      .clk(clk), .rst(rst),
      .i_start(launch_q), .i_byte(tx_byte_q), .o_tx(o_tx), .o_busy(tx_active)
   );

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
      .clk(clk), .rst(rst),
      .i_rx(i_rx), .o_rx(o_rx), .o_valid(o_rx_valid)
   );

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              i_rx,
   output uart_dbg_pkg::rx_result_t o_rx,
   output logic                   o_valid
);

   localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF     = CNT_W'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_DATA,
      S_STOP
   } state_t;

   state_t           state;
   logic [1:0]       sync;     // Two-flop synchronizer
   logic             rx_prev;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_idx;
   logic [7:0]       shreg;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         sync    <= 2'b11;
         rx_prev <= 1'b1;
      end
      else
      begin
         sync    <= {sync[0], i_rx};
         rx_prev <= sync[1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= S_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         o_valid  <= 1'b0;
      end
      else
      begin
         o_valid <= 1'b0;
         case (state)
            S_IDLE:
            begin
               baud_cnt <= '0;
               bit_idx  <= '0;
               if (rx_prev && !sync[1])
                  state <= S_START; // Falling edge
            end
            S_START:
            begin
               baud_cnt <= baud_cnt + 1'b1;
               if (baud_cnt == HALF)
               begin
                  baud_cnt <= '0;
                  state    <= sync[1] ? S_IDLE : S_DATA; // Glitch check
               end
            end
            S_DATA:
            begin
               baud_cnt <= baud_cnt + 1'b1;
               if (baud_cnt == BIT_LAST)
               begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= S_STOP;
               end
            end
            S_STOP:
            begin
               baud_cnt <= baud_cnt + 1'b1;
               if (baud_cnt == BIT_LAST)
               begin
                  o_valid <= 1'b1;
                  state   <= S_IDLE;
               end
            end
         endcase
      end
   end

   // Received payload arrives LSB first
   always_ff @(posedge clk)
   begin
      if (state == S_DATA && baud_cnt == BIT_LAST)
         shreg <= {sync[1], shreg[7:1]};
      if (state == S_STOP && baud_cnt == BIT_LAST)
      begin
         o_rx.data      <= shreg;
         o_rx.frame_err <= !sync[1];
      end
   end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       i_start,
   input  wire logic [7:0] i_byte,
   output logic            o_tx,
   output logic            o_busy
);

   localparam int              CNT_W    = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

   logic [9:0]       frame;    // Stop, data LSB first, start
   logic [CNT_W-1:0] baud_cnt;
   logic [3:0]       bit_idx;  // Bit now on the line

   // Line idles high
   assign o_tx = o_busy ? frame[bit_idx] : 1'b1;

   always_ff @(posedge clk)
   begin
      if (!o_busy && i_start)
      begin
         frame <= {1'b1, i_byte, 1'b0};
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         o_busy   <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end
      else if (!o_busy)
      begin
         if (i_start)
         begin
            o_busy   <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
         end
      end
      else if (baud_cnt == BIT_LAST)
      begin
         baud_cnt <= '0;
         if (bit_idx == 4'd9)
            o_busy <= 1'b0; // End of stop bit
         else
            bit_idx <= bit_idx + 1'b1;
      end
      else
      begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+sim
design/uart_dbg_pkg.sv
design/hex_line_formatter.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_dbg_top.sv
sim/tb_uart_dbg.sv

// ==== sim/tb_uart_dbg_tasks.svh ====
`ifndef TB_UART_DBG_TASKS_SVH
`define TB_UART_DBG_TASKS_SVH

task automatic log_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
   $display("MISMATCH time %0d ns: %s expected %0h got %0h", $time, sig, exp, act);
   err_count++;
endtask

task automatic log_failure(input string msg);
   $display("ERROR time %0d ns: %s", $time, msg);
   err_count++;
endtask

task automatic finish_test(input string name, input int errs_before);
   tests_run++;
   if (err_count == errs_before)
   begin
      $display("%s: PASS", name);
   end
   else
   begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, err_count - errs_before);
   end
endtask

// One 8N1 frame from o_tx sampled at mid-bit on the falling clock
task automatic capture_byte(output logic [7:0] b);
   @(negedge o_tx);
   repeat (CLKS_PER_BIT / 2) @(negedge clk);
   if (o_tx !== 1'b0)
      log_failure("start bit on o_tx is not low at mid-bit");
   for (int i = 0; i < 8; i++)
   begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = o_tx; // LSB first
   end
   repeat (CLKS_PER_BIT) @(negedge clk);
   if (o_tx !== 1'b1)
      log_failure("stop bit on o_tx is not high");
endtask

task automatic send_byte(input logic [7:0] data, input logic bad_stop);
   @(posedge clk);
   i_rx <= 1'b0;
   repeat (CLKS_PER_BIT) @(posedge clk);
   for (int i = 0; i < 8; i++)
   begin
      i_rx <= data[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
   end
   i_rx <= !bad_stop;
   repeat (CLKS_PER_BIT) @(posedge clk);
   i_rx <= 1'b1;
   repeat (2 * CLKS_PER_BIT) @(posedge clk); // Idle gap
endtask

task automatic strobe_line(input logic [DATA_W-1:0] value, input logic [1:0] reg_num);
   int cycles;
   cycles = 0;
   @(negedge clk);
   while (o_tx_busy !== 1'b0 && cycles < LINE_TIMEOUT)
   begin
      @(negedge clk);
      cycles++;
   end
   if (cycles >= LINE_TIMEOUT)
      log_failure("o_tx_busy never went low before a strobe");
   @(posedge clk);
   i_tx_stb  <= 1'b1;
   i_tx_data <= value;
   i_reg_num <= reg_num;
   @(posedge clk);
   i_tx_stb <= 1'b0;
endtask

task automatic wait_tx_bytes(input int n);
   int cycles;
   cycles = 0;
   while (tx_q.size() < n && cycles < LINE_TIMEOUT)
   begin
      @(negedge clk);
      cycles++;
   end
   if (tx_q.size() < n)
      log_failure($sformatf("only %0d of %0d bytes arrived on o_tx", tx_q.size(), n));
endtask

task automatic wait_rx_results(input int n);
   int cycles;
   cycles = 0;
   while (rx_q.size() < n && cycles < 2 * FRAME_CLKS)
   begin
      @(negedge clk);
      cycles++;
   end
   if (rx_q.size() != n)
      log_failure($sformatf("expected %0d o_rx_valid pulses, saw %0d", n, rx_q.size()));
endtask

// Expected line is "R", register digit, ":", hex MSB first, LF, CR
task automatic check_line(input logic [DATA_W-1:0] value, input logic [1:0] reg_num);
   string      hex_digits;
   logic [7:0] exp_line [$];
   logic [7:0] got;
   logic [3:0] nib;
   hex_digits = "0123456789ABCDEF";
   exp_line.push_back("R");
   exp_line.push_back(hex_digits[reg_num]);
   exp_line.push_back(":");
   for (int i = DATA_W / 4 - 1; i >= 0; i--)
   begin
      nib = value[i*4 +: 4];
      exp_line.push_back(hex_digits[nib]);
   end
   exp_line.push_back(8'h0a);
   exp_line.push_back(8'h0d);
   wait_tx_bytes(exp_line.size());
   foreach (exp_line[i])
   begin
      if (tx_q.size() == 0)
         return;
      got = tx_q.pop_front();
      if (got !== exp_line[i])
         log_mismatch($sformatf("o_tx byte %0d", i), exp_line[i], got);
   end
endtask

task automatic test_reset_state();
   int errs;
   errs = err_count;
   @(negedge clk);
   if (o_tx !== 1'b1)
      log_mismatch("o_tx", 1, o_tx);
   if (o_tx_busy !== 1'b0)
      log_mismatch("o_tx_busy", 0, o_tx_busy);
   if (o_rx_valid !== 1'b0)
      log_mismatch("o_rx_valid", 0, o_rx_valid);
   finish_test("reset_state", errs);
endtask

task automatic test_fixed_line();
   int errs;
   errs = err_count;
   tx_q.delete();
   strobe_line(16'h1234, 2'd1);
   @(negedge clk);
   if (o_tx_busy !== 1'b1)
      log_mismatch("o_tx_busy", 1, o_tx_busy);
   check_line(16'h1234, 2'd1);
   repeat (2 * FRAME_CLKS) @(negedge clk);
   if (tx_q.size() != 0)
      log_failure("extra bytes sent after the carriage return");
   finish_test("fixed_line", errs);
endtask

task automatic test_all_registers();
   int          errs;
   logic [31:0] rnd;
   errs = err_count;
   tx_q.delete();
   for (int r = 0; r < 4; r++)
   begin
      rnd = $random(seed);
      strobe_line(rnd[DATA_W-1:0], r[1:0]);
      check_line(rnd[DATA_W-1:0], r[1:0]);
   end
   strobe_line(16'hABEF, 2'd2); // All letter digits
   check_line(16'hABEF, 2'd2);
   finish_test("all_registers", errs);
endtask

task automatic test_busy_strobe();
   int errs;
   errs = err_count;
   tx_q.delete();
   strobe_line(16'h5A0C, 2'd3);
   @(negedge clk);
   if (o_tx_busy !== 1'b1)
      log_failure("o_tx_busy low when the second strobe was due");
   @(posedge clk);
   i_tx_stb  <= 1'b1;
   i_tx_data <= 16'hFFFF;
   i_reg_num <= 2'd0;
   @(posedge clk);
   i_tx_stb <= 1'b0;
   check_line(16'h5A0C, 2'd3);
   repeat (2 * FRAME_CLKS) @(negedge clk);
   if (tx_q.size() != 0)
      log_failure("extra bytes sent after a strobe during busy");
   strobe_line(16'h0F19, 2'd2);
   check_line(16'h0F19, 2'd2);
   finish_test("busy_strobe", errs);
endtask

task automatic test_rx_good();
   int          errs;
   logic [7:0]  bytes [4];
   logic [31:0] rnd;
   rx_result_t  res;
   errs = err_count;
   rnd = $random(seed);
   bytes[0] = 8'h55;
   bytes[1] = 8'h00;
   bytes[2] = 8'hFF;
   bytes[3] = rnd[7:0];
   foreach (bytes[i])
   begin
      rx_q.delete();
      send_byte(bytes[i], 1'b0);
      wait_rx_results(1);
      if (rx_q.size() > 0)
      begin
         res = rx_q.pop_front();
         if (res.data !== bytes[i])
            log_mismatch("o_rx.data", bytes[i], res.data);
         if (res.frame_err !== 1'b0)
            log_mismatch("o_rx.frame_err", 0, res.frame_err);
      end
   end
   finish_test("rx_good", errs);
endtask

task automatic test_rx_frame_err();
   int         errs;
   rx_result_t res;
   errs = err_count;
   rx_q.delete();
   send_byte(8'hC6, 1'b1); // Stop bit held low
   wait_rx_results(1);
   if (rx_q.size() > 0)
   begin
      res = rx_q.pop_front();
      if (res.data !== 8'hC6)
         log_mismatch("o_rx.data", 8'hC6, res.data);
      if (res.frame_err !== 1'b1)
         log_mismatch("o_rx.frame_err", 1, res.frame_err);
   end
   finish_test("rx_frame_err", errs);
endtask

`endif

// ==== sim/tb_uart_dbg.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uart_dbg;

   import uart_dbg_pkg::*;

   localparam int DATA_W       = 16;
   localparam int CLKS_PER_BIT = 8;
   localparam int FIFO_DEPTH   = 4;
   localparam int CLK_NS       = 4;
   localparam int LINE_BYTES   = DATA_W / 4 + 5;
   localparam int NUM_TESTS    = 6;
   localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
   localparam int LINE_TIMEOUT = 4 * LINE_BYTES * FRAME_CLKS; // In clock cycles
   localparam int WATCHDOG_NS  = NUM_TESTS * LINE_BYTES * FRAME_CLKS * CLK_NS * 4;

   logic              clk;
   logic              rst;
   logic              i_tx_stb;
   logic [DATA_W-1:0] i_tx_data;
   logic [1:0]        i_reg_num;
   logic              i_rx;
   logic              o_tx_busy;
   logic              o_tx;
   rx_result_t        o_rx;
   logic              o_rx_valid;

   logic [7:0] tx_q [$]; // Bytes decoded from o_tx
   rx_result_t rx_q [$]; // One receiver result per valid pulse
   int         err_count;
   int         tests_run;
   int         tests_failed;
   integer     seed;

   `include "tb_uart_dbg_tasks.svh"

   uart_dbg_top #(
      .DATA_W(DATA_W),
      .CLKS_PER_BIT(CLKS_PER_BIT),
      .FIFO_DEPTH(FIFO_DEPTH)
   ) dut (
      .clk(clk),
      .rst(rst),
      .i_tx_stb(i_tx_stb),
      .i_tx_data(i_tx_data),
      .i_reg_num(i_reg_num),
      .i_rx(i_rx),
      .o_tx_busy(o_tx_busy),
      .o_tx(o_tx),
      .o_rx(o_rx),
      .o_rx_valid(o_rx_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Serial monitor on o_tx
   initial
   begin
      logic [7:0] b;
      wait (rst === 1'b0);
      forever
      begin
         capture_byte(b);
         tx_q.push_back(b);
      end
   end

   // Receiver results sampled away from the active edge
   initial
   begin
      wait (rst === 1'b0);
      forever
      begin
         @(negedge clk);
         if (o_rx_valid === 1'b1)
            rx_q.push_back(o_rx);
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      seed         = 32'h4ecfe2db;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      rst          = 1'b1;
      i_tx_stb     = 1'b0;
      i_tx_data    = '0;
      i_reg_num    = '0;
      i_rx         = 1'b1; // Idle line
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      test_reset_state();
      test_fixed_line();
      test_all_registers();
      test_busy_strobe();
      test_rx_good();
      test_rx_frame_err();
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, err_count);
      if (err_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
